// File: rate_match_harq.f
src/rm_pkg.sv
src/harq_rd_if.sv
src/harq_buffer.sv
src/k0_calc.sv
src/circular_reader.sv
src/rate_match_harq.sv
testbench/rate_match_harq_chk.sv
testbench/rm_scoreboard.sv
testbench/tb_rate_match_harq.sv

// File: Makefile
BIN  := obj_dir/Vtb_rate_match_harq
SRCS := $(wildcard src/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): rate_match_harq.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_rate_match_harq -f rate_match_harq.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_rate_match_harq.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rate_match_harq;
    import rm_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 16;
    localparam int N_JOBS     = 9;

    typedef struct packed {
        logic        bg;       // 0 = BG1, 1 = BG2
        logic [1:0]  rv;
        logic [8:0]  z;
        logic [2:0]  pn;
        logic [16:0] n;
        logic [16:0] e;
        logic [3:0]  spacing;  // idle cycles between credit returns
        logic        fill;     // write fresh words before the job
        logic [14:0] k0;       // expected start position
    } job_t;

    localparam job_t JOBS [N_JOBS] = '{
        '{1'b0, 2'd0, 9'd16, 3'd0, 17'd1056, 17'd700,  4'd0, 1'b1, 15'd0},    // truncation
        '{1'b0, 2'd2, 9'd16, 3'd0, 17'd1056, 17'd600,  4'd0, 1'b0, 15'd528},
        '{1'b1, 2'd1, 9'd10, 3'd1, 17'd500,  17'd400,  4'd1, 1'b1, 15'd130},
        '{1'b1, 2'd3, 9'd10, 3'd1, 17'd500,  17'd300,  4'd0, 1'b0, 15'd430},
        '{1'b0, 2'd1, 9'd8,  3'd3, 17'd528,  17'd1300, 4'd0, 1'b1, 15'd136},  // repetition
        '{1'b1, 2'd0, 9'd6,  3'd2, 17'd300,  17'd200,  4'd0, 1'b1, 15'd0},
        '{1'b0, 2'd3, 9'd6,  3'd5, 17'd396,  17'd250,  4'd0, 1'b1, 15'd336},
        '{1'b1, 2'd2, 9'd6,  3'd2, 17'd300,  17'd320,  4'd3, 1'b0, 15'd150},  // process 2 again
        '{1'b0, 2'd1, 9'd12, 3'd4, 17'd792,  17'd400,  4'd7, 1'b1, 15'd204}   // slow consumer
    };

    logic        clk        = 1'b0;
    logic        rst;
    logic        wr_valid;
    logic        wr_first;
    pn_t         wr_pn;
    word_t       wr_data;
    logic        start;
    logic        base_graph;
    rv_t         rv;
    lift_t       z;
    pn_t         pn;
    len_t        data_size;
    len_t        e_len;
    logic        credit_ret = 1'b0;
    logic        out_bit;
    logic        out_valid;
    logic        busy;
    logic        done;

    logic [31:0] lfsr       = 32'h92a5_796c;
    int          spacing    = 0;
    int          owed       = 0;  // beats received, credit not yet returned
    int          gap        = 0;
    int          tb_errors  = 0;
    int          sb_errors;
    int          sb_dones;
    int          chk_errors;

    rate_match_harq dut_i (
        .clk        (clk),
        .rst        (rst),
        .wr_valid   (wr_valid),
        .wr_first   (wr_first),
        .wr_pn      (wr_pn),
        .wr_data    (wr_data),
        .start      (start),
        .base_graph (base_graph),
        .rv         (rv),
        .z          (z),
        .pn         (pn),
        .data_size  (data_size),
        .e_len      (e_len),
        .credit_ret (credit_ret),
        .out_bit    (out_bit),
        .out_valid  (out_valid),
        .busy       (busy),
        .done       (done)
    );

    rm_scoreboard scoreboard_i (
        .clk        (clk),
        .rst        (rst),
        .wr_valid   (wr_valid),
        .wr_first   (wr_first),
        .wr_pn      (wr_pn),
        .wr_data    (wr_data),
        .start      (start),
        .base_graph (base_graph),
        .rv         (rv),
        .z          (z),
        .pn         (pn),
        .data_size  (data_size),
        .e_len      (e_len),
        .out_bit    (out_bit),
        .out_valid  (out_valid),
        .busy       (busy),
        .done       (done),
        .err_cnt    (sb_errors),
        .done_cnt   (sb_dones)
    );

    initial
    begin
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] nxt;
        nxt = {1'b0, s[31:1]};
        if (s[0])
        begin
            nxt = nxt ^ 32'hA300_0000;
        end
        return nxt;
    endfunction

    function automatic int watchdog_cycles();
        int total;
        int sum_e;
        int widest;
        int k;
        total  = RST_CYCLES + 500;
        sum_e  = 0;
        widest = 0;
        for (k = 0; k < N_JOBS; k++)
        begin
            total = total + (int'(JOBS[k].n) + 127) / 128 + 50;
            sum_e = sum_e + int'(JOBS[k].e);
            if (int'(JOBS[k].spacing) > widest)
            begin
                widest = int'(JOBS[k].spacing);
            end
        end
        return total + sum_e * (widest + 1);
    endfunction

    task automatic build_word(output word_t w);
        logic [7:0] b;
        for (b = 8'd0; b < 8'd128; b++)
        begin
            w[b[6:0]] = lfsr[0];  // one step per bit
            lfsr      = lfsr_step(lfsr);
        end
    endtask

    task automatic fill_process(input pn_t p, input len_t n);
        int    words;
        int    i;
        word_t w;
        words = (int'(n) + 127) / 128;
        for (i = 0; i < words; i++)
        begin
            build_word(w);
            wr_valid = 1'b1;
            wr_first = (i == 0);
            wr_pn    = p;
            wr_data  = w;
            @(negedge clk);
        end
        wr_valid = 1'b0;
        wr_first = 1'b0;
    endtask

    task automatic run_job(input job_t j);
        if (j.fill)
        begin
            fill_process(j.pn, j.n);
        end
        spacing    = int'(j.spacing);
        base_graph = j.bg;
        rv         = j.rv;
        z          = j.z;
        pn         = j.pn;
        data_size  = j.n;
        e_len      = j.e;
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (dut_i.k0 !== j.k0)
        begin
            $display("[FAIL] k0 = %h, expected %h", dut_i.k0, j.k0);
            tb_errors++;
        end
        while (done !== 1'b1)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        while (owed != 0)  // let the consumer pay back every beat
        begin
            @(posedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    // consumer side, one credit back per beat taken
    always @(negedge clk)
    begin
        if (out_valid === 1'b1)
        begin
            owed = owed + 1;
        end
        credit_ret = 1'b0;
        if (gap > 0)
        begin
            gap = gap - 1;
        end
        else if (owed > 0)
        begin
            credit_ret = 1'b1;
            owed       = owed - 1;
            gap        = spacing;
        end
    end

    initial
    begin
        repeat (watchdog_cycles()) @(posedge clk);
        $display("timeout: the jobs did not finish in the allowed number of cycles");
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        int j;
        rst        = 1'b1;
        wr_valid   = 1'b0;
        wr_first   = 1'b0;
        wr_pn      = '0;
        wr_data    = '0;
        start      = 1'b0;
        base_graph = 1'b0;
        rv         = '0;
        z          = '0;
        pn         = '0;
        data_size  = '0;
        e_len      = '0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (8) @(negedge clk);  // outputs must stay quiet here
        for (j = 0; j < N_JOBS; j++)
        begin
            run_job(JOBS[j]);
        end
        repeat (4) @(negedge clk);
        if (sb_dones != N_JOBS)
        begin
            $display("done pulsed %0d times for %0d jobs", sb_dones, N_JOBS);
            tb_errors++;
        end
        chk_errors = dut_i.chk_i.fail_total;
        $display("errors: testbench %0d, scoreboard %0d, assertions %0d",
                 tb_errors, sb_errors, chk_errors);
        if (tb_errors + sb_errors + chk_errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/rm_scoreboard.sv
`timescale 1ns/100ps
`default_nettype none

module rm_scoreboard (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          wr_valid,
    input  wire logic          wr_first,
    input  wire rm_pkg::pn_t   wr_pn,
    input  wire rm_pkg::word_t wr_data,
    input  wire logic          start,
    input  wire logic          base_graph,
    input  wire rm_pkg::rv_t   rv,
    input  wire rm_pkg::lift_t z,
    input  wire rm_pkg::pn_t   pn,
    input  wire rm_pkg::len_t  data_size,
    input  wire rm_pkg::len_t  e_len,
    input  wire logic          out_bit,
    input  wire logic          out_valid,
    input  wire logic          busy,
    input  wire logic          done,
    output int                 err_cnt,
    output int                 done_cnt
);
    import rm_pkg::*;

    word_t mirror [NUM_PROC][NUM_WORDS];  // copy of every HARQ buffer
    int    wr_ptr  = 0;
    int    waddr   = 0;
    int    job_id  = 0;   // bumps on every accepted start
    int    cur_job = 0;
    int    beat    = 0;
    int    job_k0  = 0;
    int    job_n   = 1;
    int    job_e   = 0;
    pn_t   job_pn  = '0;
    int    pos     = 0;
    logic  exp_bit;
    logic  rst_q   = 1'b1;
    logic  busy_q  = 1'b0;
    int    errors  = 0;
    int    dones   = 0;

    assign err_cnt  = errors;
    assign done_cnt = dones;

    // redundancy version start factors, k0 = factor * Z
    function automatic int rv_factor(input logic bg, input rv_t r);
        case ({bg, r})
            3'b000:  return 0;
            3'b001:  return 17;
            3'b010:  return 33;
            3'b011:  return 56;
            3'b100:  return 0;
            3'b101:  return 13;
            3'b110:  return 25;
            default: return 43;
        endcase
    endfunction

    // inputs change on the falling edge, so they are taken here
    always @(posedge clk)
    begin
        rst_q = rst;
        if (rst)
        begin
            wr_ptr = 0;
        end
        else if (wr_valid)
        begin
            waddr = wr_first ? 0 : wr_ptr;
            if (waddr < NUM_WORDS)
            begin
                mirror[wr_pn][8'(waddr)] = wr_data;
            end
            wr_ptr = waddr + 1;
        end
        if (!rst && start && !busy_q)
        begin
            job_k0 = rv_factor(base_graph, rv) * int'(z);
            job_n  = int'(data_size);
            job_e  = int'(e_len);
            job_pn = pn;
            job_id = job_id + 1;
        end
    end

    // outputs settle after the rising edge
    always @(negedge clk)
    begin
        busy_q = busy;
        if (!rst_q)
        begin
            if (job_id == 0 && (out_valid | busy | done) === 1'b1)
            begin
                $display("outputs became active before the first start");
                errors = errors + 1;
            end
            if (job_id != cur_job)
            begin
                cur_job = job_id;
                beat    = 0;
            end
            if (out_valid === 1'b1)
            begin
                if (beat >= job_e)
                begin
                    $display("output beat %0d arrived after all %0d bits of the job", beat, job_e);
                    errors = errors + 1;
                end
                else
                begin
                    pos     = (job_k0 + beat) % job_n;  // circular read from k0
                    exp_bit = mirror[job_pn][8'(pos / WORD_W)][7'(pos % WORD_W)];
                    if (out_bit !== exp_bit)
                    begin
                        $display("[FAIL] out_bit = %h, expected %h, beat %h", out_bit, exp_bit,
                                 beat);
                        errors = errors + 1;
                    end
                end
                beat = beat + 1;
            end
            if (done === 1'b1)
            begin
                dones = dones + 1;
                if (beat != job_e)
                begin
                    $display("done came after %0d beats instead of %0d", beat, job_e);
                    errors = errors + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/rate_match_harq_chk.sv
`timescale 1ns/100ps
`default_nettype none

module rate_match_harq_chk (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic credit_ret,
    input  wire logic out_valid,
    input  wire logic busy,
    input  wire logic done
);
    import rm_pkg::*;

    logic [5:0] unreturned;  // beats on the stream not yet paid back
    int         reset_fails  = 0;
    int         idle_fails   = 0;
    int         credit_fails = 0;
    int         done_fails   = 0;
    int         fail_total;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            unreturned <= '0;
        end
        else
        begin
            unreturned <= unreturned + 6'(out_valid) - 6'(credit_ret);
        end
    end

    assign fail_total = reset_fails + idle_fails + credit_fails + done_fails;

    a_reset_state: assert property (@(posedge clk) rst |=> (!out_valid && !busy && !done))
        else begin $error("outputs not cleared by reset"); reset_fails++; end

    // nothing leaves the reader while it is idle
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst) !busy |-> !out_valid)
        else begin $error("out_valid while idle"); idle_fails++; end

    a_credit_limit: assert property (@(posedge clk) disable iff (rst)
                                     unreturned <= 6'(CREDIT_MAX))
        else begin $error("unreturned beats exceed the credit limit"); credit_fails++; end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |-> !busy ##1 !done)
        else begin $error("done is not a single pulse at the end of a job"); done_fails++; end

endmodule

bind rate_match_harq rate_match_harq_chk chk_i (
    .clk        (clk),
    .rst        (rst),
    .credit_ret (credit_ret),
    .out_valid  (out_valid),
    .busy       (busy),
    .done       (done)
);

`default_nettype wire

// File: src/rate_match_harq.sv
`timescale 1ns/100ps
`default_nettype none

module rate_match_harq (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          wr_valid,
    input  wire logic          wr_first,
    input  wire rm_pkg::pn_t   wr_pn,
    input  wire rm_pkg::word_t wr_data,
    input  wire logic          start,
    input  wire logic          base_graph,  // 0 = BG1, 1 = BG2
    input  wire rm_pkg::rv_t   rv,
    input  wire rm_pkg::lift_t z,
    input  wire rm_pkg::pn_t   pn,
    input  wire rm_pkg::len_t  data_size,   // codeword length N
    input  wire rm_pkg::len_t  e_len,       // output length E
    input  wire logic          credit_ret,
    output logic               out_bit,
    output logic               out_valid,
    output logic               busy,
    output logic               done
);
    import rm_pkg::*;

    bit_pos_t k0;
    logic     k0_valid;

    harq_rd_if rd_if ();

    harq_buffer buffer_i (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (wr_valid),
        .wr_first (wr_first),
        .wr_pn    (wr_pn),
        .wr_data  (wr_data),
        .rd       (rd_if.buffer)
    );

    k0_calc k0_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .base_graph (base_graph),
        .rv         (rv),
        .z          (z),
        .k0         (k0),
        .k0_valid   (k0_valid)
    );

    circular_reader reader_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .pn         (pn),
        .data_size  (data_size),
        .e_len      (e_len),
        .k0         (k0),
        .k0_valid   (k0_valid),
        .credit_ret (credit_ret),
        .rd         (rd_if.reader),
        .out_bit    (out_bit),
        .out_valid  (out_valid),
        .busy       (busy),
        .done       (done)
    );

endmodule

`default_nettype wire

// File: src/circular_reader.sv
`timescale 1ns/100ps
`default_nettype none

module circular_reader (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             start,
    input  wire rm_pkg::pn_t      pn,
    input  wire rm_pkg::len_t     data_size,
    input  wire rm_pkg::len_t     e_len,
    input  wire rm_pkg::bit_pos_t k0,
    input  wire logic             k0_valid,
    input  wire logic             credit_ret,
    harq_rd_if.reader             rd,
    output logic                  out_bit,
    output logic                  out_valid,
    output logic                  busy,
    output logic                  done
);
    import rm_pkg::*;

    rd_state_t  state;
    pn_t        pn_r;
    len_t       size_m1;      // position of the last codeword bit
    len_t       rem;          // beats still to emit
    len_t       f_rem;        // beats not yet covered by a fetch
    bit_pos_t   pos;          // next bit to emit
    bit_pos_t   f_pos;        // first bit of the next fetch
    word_t      q_data [2];   // two-word queue
    logic       q_wr;
    logic       q_rd;
    logic [1:0] q_cnt;
    credit_t    credit;
    logic       fin_q;        // final beat is on the output

    logic       f_is_last;
    len_t       f_cover;
    logic       emit;
    logic       pos_wrap;
    logic       pop;
    bit_sel_t   bit_idx;

    // bits the next fetch contributes, short at the codeword end
    always_comb
    begin
        f_is_last = (f_pos[14:7] == size_m1[14:7]);
        if (f_is_last)
        begin
            f_cover = size_m1 - len_t'(f_pos) + 1'b1;
        end
        else
        begin
            f_cover = len_t'(WORD_W) - len_t'(f_pos[6:0]);
        end
    end

    assign rd.req  = (state == run) && (f_rem != '0) &&
                     ((q_cnt + 2'(rd.data_valid)) < 2'd2);  // room for the returning word
    assign rd.pn   = pn_r;
    assign rd.addr = f_pos[14:7];
    assign rd.last = (f_cover >= f_rem);

    assign bit_idx  = pos[6:0];
    assign pos_wrap = (len_t'(pos) == size_m1);
    assign emit     = ((state == run) || (state == drain)) && (q_cnt != '0) &&
                      (rem != '0) && (credit != '0);
    assign pop      = emit && ((bit_idx == '1) || pos_wrap);  // head word used up

    assign busy = (state != idle);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= idle;
            rem       <= '0;
            f_rem     <= '0;
            pos       <= '0;
            f_pos     <= '0;
            q_wr      <= 1'b0;
            q_rd      <= 1'b0;
            q_cnt     <= '0;
            credit    <= credit_t'(CREDIT_MAX);
            out_valid <= 1'b0;
            fin_q     <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            out_valid <= emit;
            fin_q     <= emit && (rem == len_t'(1));
            done      <= fin_q || ((state == wait_k0) && k0_valid && (rem == '0));
            q_cnt     <= q_cnt + 2'(rd.data_valid) - 2'(pop);  // start clears it below

            case (state)
                idle:
                begin
                    if (start)
                    begin
                        state <= wait_k0;
                        rem   <= e_len;
                        f_rem <= e_len;
                        q_wr  <= 1'b0;
                        q_rd  <= 1'b0;
                        q_cnt <= '0;
                    end
                end
                wait_k0:
                begin
                    if (k0_valid)
                    begin
                        state <= (rem == '0) ? idle : run;  // empty job ends at once
                        pos   <= k0;
                        f_pos <= k0;
                    end
                end
                run:
                begin
                    if (rd.data_valid && rd.data_last)
                    begin
                        state <= drain;
                    end
                end
                default:
                begin
                    // drain waits for the final beat
                end
            endcase

            if (fin_q)
            begin
                state <= idle;
            end

            if (rd.req)
            begin
                f_rem <= rd.last ? '0 : f_rem - f_cover;
                f_pos <= f_is_last ? '0 : bit_pos_t'({word_addr_t'(f_pos[14:7] + 1'b1), 7'd0});
            end

            if (emit)
            begin
                rem <= rem - 1'b1;
                pos <= pos_wrap ? '0 : pos + 1'b1;  // wrap at N
            end

            if (rd.data_valid)
            begin
                q_wr <= ~q_wr;
            end
            if (pop)
            begin
                q_rd <= ~q_rd;
            end

            // one credit per beat, back on credit_ret
            case ({emit, credit_ret})
                2'b10:   credit <= credit - 1'b1;
                2'b01:   credit <= credit + 1'b1;
                default: credit <= credit;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == idle && start)
        begin
            pn_r    <= pn;
            size_m1 <= data_size - 1'b1;
        end
        if (rd.data_valid)
        begin
            q_data[q_wr] <= rd.data;
        end
        if (emit)
        begin
            out_bit <= q_data[q_rd][bit_idx];
        end
    end

endmodule

`default_nettype wire

// File: src/k0_calc.sv
`timescale 1ns/100ps
`default_nettype none

module k0_calc (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            start,
    input  wire logic            base_graph,  // 0 = BG1, 1 = BG2
    input  wire rm_pkg::rv_t     rv,
    input  wire rm_pkg::lift_t   z,
    output rm_pkg::bit_pos_t     k0,
    output logic                 k0_valid
);
    import rm_pkg::*;

    logic [5:0] factor;
    bit_pos_t   product;

    always_comb
    begin
        if (base_graph)
        begin
            factor = RV_FACTOR_BG2[rv];
        end
        else
        begin
            factor = RV_FACTOR_BG1[rv];
        end
    end

    // largest case 56 * 384 still fits 15 bits
    assign product = bit_pos_t'(factor) * bit_pos_t'(z);

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            k0 <= product;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            k0_valid <= 1'b0;
        end
        else
        begin
            k0_valid <= start;  // one pulse per start
        end
    end

endmodule

`default_nettype wire

// File: src/harq_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module harq_buffer (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          wr_valid,
    input  wire logic          wr_first,
    input  wire rm_pkg::pn_t   wr_pn,
    input  wire rm_pkg::word_t wr_data,
    harq_rd_if.buffer          rd
);
    import rm_pkg::*;

    word_t      mem [NUM_PROC][NUM_WORDS];  // one word array per HARQ process
    word_addr_t wr_ptr;
    word_addr_t wr_addr;

    // wr_first restarts the fill at word 0
    assign wr_addr = wr_first ? '0 : wr_ptr;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
        end
        else if (wr_valid)
        begin
            wr_ptr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_valid && (wr_addr < word_addr_t'(NUM_WORDS)))  // drop overflow words
        begin
            mem[wr_pn][wr_addr] <= wr_data;
        end
        if (rd.req)
        begin
            rd.data <= mem[rd.pn][rd.addr];
        end
    end

    // valid and last follow the data by one cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rd.data_valid <= 1'b0;
            rd.data_last  <= 1'b0;
        end
        else
        begin
            rd.data_valid <= rd.req;
            rd.data_last  <= rd.req && rd.last;
        end
    end

endmodule

`default_nettype wire

// File: src/harq_rd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface harq_rd_if;
    import rm_pkg::*;

    logic       req;         // one word read
    pn_t        pn;
    word_addr_t addr;
    logic       last;        // request carries the final bits of the job
    word_t      data;        // word, one cycle after req
    logic       data_valid;
    logic       data_last;   // last, delayed with the data

    modport reader (
        output req,
        output pn,
        output addr,
        output last,
        input  data,
        input  data_valid,
        input  data_last
    );

    modport buffer (
        input  req,
        input  pn,
        input  addr,
        input  last,
        output data,
        output data_valid,
        output data_last
    );

endinterface

`default_nettype wire

// File: src/rm_pkg.sv
`default_nettype none

package rm_pkg;

    localparam int WORD_W     = 128;
    localparam int NUM_WORDS  = 200;  // 20 rows x 10 columns per process
    localparam int NUM_PROC   = 8;
    localparam int CREDIT_MAX = 8;    // credits granted after reset

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [7:0]        word_addr_t;  // word index inside one process
    typedef logic [6:0]        bit_sel_t;    // bit index inside one word
    typedef logic [14:0]       bit_pos_t;    // bit position inside a codeword
    typedef logic [16:0]       len_t;        // E or N
    typedef logic [2:0]        pn_t;
    typedef logic [1:0]        rv_t;
    typedef logic [8:0]        lift_t;
    typedef logic [3:0]        credit_t;

    // k0 = factor * Z, indexed by RV
    localparam logic [5:0] RV_FACTOR_BG1 [4] = '{6'd0, 6'd17, 6'd33, 6'd56};
    localparam logic [5:0] RV_FACTOR_BG2 [4] = '{6'd0, 6'd13, 6'd25, 6'd43};

    typedef enum logic [1:0] {
        idle,
        wait_k0,  // start taken, k0 not yet known
        run,      // fetching and emitting
        drain     // final word fetched, emitting the rest
    } rd_state_t;

endpackage

`default_nettype wire
